//--- rtl/dconv_config.svh
`ifndef DCONV_CONFIG_SVH
`define DCONV_CONFIG_SVH

// Signed pixel and weight width
`define DATA_WIDTH 16

// Frame size in pixels
`define IMAGE_WIDTH 8
`define IMAGE_HEIGHT 8

// Dilation between neighbouring taps
// Works with 1, 2 or 3 on an 8x8 frame
`define RATE 2

// Signed accumulator width
`define ACC_WIDTH 40

// APB byte address width
`define APB_ADDR_WIDTH 8

`endif

//--- rtl/dconv_pkg.sv
`default_nettype none
`include "dconv_config.svh"

package dconv_pkg;

  ////////////////////////////////////////
  // Streaming beats
  ////////////////////////////////////////

  // One pixel per beat in raster order
  typedef struct packed {
    logic                          valid;
    logic                          sof;
    logic signed [`DATA_WIDTH-1:0] data;
  } pxl_beat_t;

  // Nine taps, index 0 is top-left, row-major
  typedef struct packed {
    logic                         valid;
    logic [8:0][`DATA_WIDTH-1:0]  taps;
  } window_beat_t;

  typedef struct packed {
    logic                         valid;
    logic signed [`ACC_WIDTH-1:0] acc;
  } acc_beat_t;

  ////////////////////////////////////////
  // APB
  ////////////////////////////////////////

  typedef struct packed {
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [`APB_ADDR_WIDTH-1:0] paddr;
    logic [31:0]                pwdata;
  } apb_req_t;

  typedef struct packed {
    logic        pready;
    logic        pslverr;
    logic [31:0] prdata;
  } apb_rsp_t;

  // Register file contents seen by the datapath
  typedef struct packed {
    logic [8:0][`DATA_WIDTH-1:0]   weights;
    logic signed [`DATA_WIDTH-1:0] bias;
    logic [4:0]                    shift;
    logic                          enable;
    logic                          relu;
  } conv_cfg_t;

  // Word index, i.e. paddr[7:2]
  typedef enum logic [`APB_ADDR_WIDTH-3:0] {
    REG_W0        = 0,
    REG_W1        = 1,
    REG_W2        = 2,
    REG_W3        = 3,
    REG_W4        = 4,
    REG_W5        = 5,
    REG_W6        = 6,
    REG_W7        = 7,
    REG_W8        = 8,
    REG_BIAS      = 9,
    REG_SHIFT     = 10,
    REG_CTRL      = 11,
    REG_OUT_COUNT = 12
  } dconv_reg_e;

endpackage

`default_nettype wire

//--- rtl/dconv_reg_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "dconv_config.svh"

module dconv_reg_decode (
  input  logic                 clk,
  input  logic                 reset,
  input  dconv_pkg::apb_req_t  apb_req,
  output dconv_pkg::apb_rsp_t  apb_rsp,
  input  logic [15:0]          out_count,
  output dconv_pkg::conv_cfg_t cfg
);

  localparam int DW = `DATA_WIDTH;
  localparam int AW = `APB_ADDR_WIDTH;

  logic                  access;
  logic                  aligned;
  logic                  mapped;
  logic                  ro_write;
  logic                  bad;
  logic [AW-3:0]         word;
  logic [31:0]           rd_data;
  dconv_pkg::dconv_reg_e reg_sel;
  dconv_pkg::conv_cfg_t  cfg_q;

  // Access phase of a transfer
  assign access  = apb_req.psel & apb_req.penable;
  assign word    = apb_req.paddr[AW-1:2];
  assign aligned = (apb_req.paddr[1:0] == 2'b00);
  assign reg_sel = dconv_pkg::dconv_reg_e'(word);

  ////////////////////////////////////////
  // Address decode and read mux
  ////////////////////////////////////////

  always_comb begin
    rd_data = '0;
    mapped  = aligned;
    case (reg_sel)
      dconv_pkg::REG_W0, dconv_pkg::REG_W1, dconv_pkg::REG_W2,
      dconv_pkg::REG_W3, dconv_pkg::REG_W4, dconv_pkg::REG_W5,
      dconv_pkg::REG_W6, dconv_pkg::REG_W7, dconv_pkg::REG_W8: begin
        rd_data = {{(32-DW){cfg_q.weights[word[3:0]][DW-1]}}, cfg_q.weights[word[3:0]]};
      end
      dconv_pkg::REG_BIAS: begin
        rd_data = {{(32-DW){cfg_q.bias[DW-1]}}, cfg_q.bias};
      end
      dconv_pkg::REG_SHIFT: rd_data = {27'd0, cfg_q.shift};
      dconv_pkg::REG_CTRL: rd_data = {30'd0, cfg_q.relu, cfg_q.enable};
      dconv_pkg::REG_OUT_COUNT: rd_data = {16'd0, out_count};
      default: mapped = 1'b0;
    endcase
  end

  // Output count is read-only
  assign ro_write = apb_req.pwrite & (reg_sel == dconv_pkg::REG_OUT_COUNT);
  assign bad      = ~mapped | ro_write;

  // No wait states
  assign apb_rsp.pready  = access;
  assign apb_rsp.pslverr = access & bad;
  assign apb_rsp.prdata  = (access & ~bad & ~apb_req.pwrite) ? rd_data : 32'd0;

  ////////////////////////////////////////
  // Register writes
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      cfg_q <= '0;
    end else if (access & apb_req.pwrite & ~bad) begin
      case (reg_sel)
        dconv_pkg::REG_BIAS: cfg_q.bias <= apb_req.pwdata[DW-1:0];
        dconv_pkg::REG_SHIFT: cfg_q.shift <= apb_req.pwdata[4:0];
        dconv_pkg::REG_CTRL: begin
          cfg_q.enable <= apb_req.pwdata[0];
          cfg_q.relu   <= apb_req.pwdata[1];
        end
        // Anything else that passed decode is a weight
        default: cfg_q.weights[word[3:0]] <= apb_req.pwdata[DW-1:0];
      endcase
    end
  end

  assign cfg = cfg_q;

endmodule

`default_nettype wire

//--- rtl/dconv_window_gather.sv
`timescale 1ns/1ps
`default_nettype none
`include "dconv_config.svh"

module dconv_window_gather (
  input  logic                    clk,
  input  logic                    reset,
  input  dconv_pkg::pxl_beat_t    pxl_in,
  input  logic                    enable,
  output dconv_pkg::window_beat_t window
);

  localparam int DW    = `DATA_WIDTH;
  localparam int W     = `IMAGE_WIDTH;
  localparam int H     = `IMAGE_HEIGHT;
  localparam int R     = `RATE;
  localparam int SPAN  = 2 * R;
  localparam int COL_W = $clog2(W);
  localparam int ROW_W = $clog2(H + 1);

  logic                    accept;
  logic [COL_W-1:0]        col_cnt;
  logic [ROW_W-1:0]        row_cnt;
  logic [COL_W-1:0]        cur_col;
  logic [ROW_W-1:0]        cur_row;
  logic                    win_valid;
  logic [DW-1:0]           line_buf [SPAN][W];
  logic [DW-1:0]           row_sr [3][SPAN];
  logic [DW-1:0]           row_px [3];
  logic [8:0][DW-1:0]      taps_next;
  logic [8:0][DW-1:0]      taps_q;
  logic                    valid_q;

  assign accept = pxl_in.valid & enable;

  // sof puts this pixel at (0,0)
  assign cur_col = pxl_in.sof ? '0 : col_cnt;
  assign cur_row = pxl_in.sof ? '0 : row_cnt;

  ////////////////////////////////////////
  // Raster position
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      col_cnt <= '0;
      row_cnt <= '0;
    end else if (accept) begin
      if (cur_col == COL_W'(W - 1)) begin
        col_cnt <= '0;
        // Parks at H if a frame runs long without sof
        row_cnt <= (cur_row == ROW_W'(H)) ? cur_row : cur_row + 1'b1;
      end else begin
        col_cnt <= cur_col + 1'b1;
        row_cnt <= cur_row;
      end
    end
  end

  ////////////////////////////////////////
  // Line buffers and row shifters
  ////////////////////////////////////////

  // Buffer k holds row r-1-k at the current column
  assign row_px[2] = pxl_in.data;
  assign row_px[1] = line_buf[R-1][cur_col];
  assign row_px[0] = line_buf[SPAN-1][cur_col];

  always_ff @(posedge clk) begin
    if (accept) begin
      line_buf[0][cur_col] <= pxl_in.data;
      for (int k = 1; k < SPAN; k++) begin
        line_buf[k][cur_col] <= line_buf[k-1][cur_col];
      end
      // Slot s holds column c-1-s of each tap row
      for (int ky = 0; ky < 3; ky++) begin
        row_sr[ky][0] <= row_px[ky];
        for (int s = 1; s < SPAN; s++) begin
          row_sr[ky][s] <= row_sr[ky][s-1];
        end
      end
    end
  end

  always_comb begin
    for (int ky = 0; ky < 3; ky++) begin
      taps_next[3*ky]     = row_sr[ky][SPAN-1];
      taps_next[3*ky + 1] = row_sr[ky][R-1];
      taps_next[3*ky + 2] = row_px[ky];
    end
  end

  // Bottom-right tap of a full dilated window
  assign win_valid = accept & (cur_row >= SPAN) & (cur_row < H) & (cur_col >= SPAN);

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= win_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (win_valid) begin
      taps_q <= taps_next;
    end
  end

  assign window = '{valid: valid_q, taps: taps_q};

endmodule

`default_nettype wire

//--- rtl/dconv_mac_array.sv
`timescale 1ns/1ps
`default_nettype none
`include "dconv_config.svh"

module dconv_mac_array (
  input  logic                    clk,
  input  logic                    reset,
  input  dconv_pkg::window_beat_t window,
  input  dconv_pkg::conv_cfg_t    cfg,
  output dconv_pkg::acc_beat_t    acc
);

  localparam int DW = `DATA_WIDTH;
  localparam int AW = `ACC_WIDTH;

  logic signed [2*DW-1:0] prod_q [9];
  logic                   prod_valid_q;
  logic signed [AW-1:0]   bias_ext;
  logic signed [AW-1:0]   sum;
  logic signed [AW-1:0]   acc_q;
  logic                   acc_valid_q;

  ////////////////////////////////////////
  // Stage 1 products
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (window.valid) begin
      for (int k = 0; k < 9; k++) begin
        prod_q[k] <= $signed(window.taps[k]) * $signed(cfg.weights[k]);
      end
    end
  end

  ////////////////////////////////////////
  // Stage 2 sum plus bias
  ////////////////////////////////////////

  // Bias is scaled up so requant can bring it back down
  assign bias_ext = $signed(cfg.bias);

  always_comb begin
    sum = bias_ext <<< cfg.shift;
    for (int k = 0; k < 9; k++) begin
      sum = sum + prod_q[k];
    end
  end

  always_ff @(posedge clk) begin
    if (prod_valid_q) begin
      acc_q <= sum;
    end
  end

  // Valid follows the data through both stages
  always_ff @(posedge clk) begin
    if (reset) begin
      prod_valid_q <= 1'b0;
      acc_valid_q  <= 1'b0;
    end else begin
      prod_valid_q <= window.valid;
      acc_valid_q  <= prod_valid_q;
    end
  end

  assign acc = '{valid: acc_valid_q, acc: acc_q};

endmodule

`default_nettype wire

//--- rtl/dconv_requant.sv
`timescale 1ns/1ps
`default_nettype none
`include "dconv_config.svh"

module dconv_requant (
  input  logic                 clk,
  input  logic                 reset,
  input  dconv_pkg::acc_beat_t acc,
  input  dconv_pkg::conv_cfg_t cfg,
  output dconv_pkg::pxl_beat_t result,
  output logic [15:0]          out_count
);

  localparam int DW         = `DATA_WIDTH;
  localparam int AW         = `ACC_WIDTH;
  localparam int FRAME_OUTS = (`IMAGE_HEIGHT - 2 * `RATE) * (`IMAGE_WIDTH - 2 * `RATE);
  localparam int IDX_W      = $clog2(FRAME_OUTS + 1);

  localparam logic signed [AW-1:0] SAT_MAX = {{(AW-DW+1){1'b0}}, {(DW-1){1'b1}}};
  localparam logic signed [AW-1:0] SAT_MIN = {{(AW-DW+1){1'b1}}, {(DW-1){1'b0}}};

  logic signed [AW-1:0] shifted;
  logic signed [AW-1:0] clipped;
  logic [DW-1:0]        sat;
  logic [DW-1:0]        data_q;
  logic                 valid_q;
  logic                 sof_q;
  logic [IDX_W-1:0]     frame_idx;
  logic [15:0]          count_q;

  // Shift down, ReLU, then clamp to the pixel range
  always_comb begin
    shifted = $signed(acc.acc) >>> cfg.shift;
    clipped = (cfg.relu && shifted < 0) ? '0 : shifted;
    if (clipped > SAT_MAX) begin
      sat = SAT_MAX[DW-1:0];
    end else if (clipped < SAT_MIN) begin
      sat = SAT_MIN[DW-1:0];
    end else begin
      sat = clipped[DW-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (acc.valid) begin
      data_q <= sat;
    end
  end

  ////////////////////////////////////////
  // Frame position and beat count
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q   <= 1'b0;
      sof_q     <= 1'b0;
      frame_idx <= '0;
      count_q   <= '0;
    end else begin
      valid_q <= acc.valid;
      sof_q   <= acc.valid & (frame_idx == '0);
      if (acc.valid) begin
        frame_idx <= (frame_idx == IDX_W'(FRAME_OUTS - 1)) ? '0 : frame_idx + 1'b1;
        count_q   <= count_q + 16'd1;
      end
    end
  end

  assign result    = '{valid: valid_q, sof: sof_q, data: data_q};
  assign out_count = count_q;

endmodule

`default_nettype wire

//--- rtl/dconv_top.sv
`timescale 1ns/1ps
`default_nettype none

module dconv_top (
  input  logic                clk,
  input  logic                reset,
  input  dconv_pkg::apb_req_t apb_req,
  output dconv_pkg::apb_rsp_t apb_rsp,
  input  dconv_pkg::pxl_beat_t pxl_in,
  output dconv_pkg::pxl_beat_t result
);

  dconv_pkg::conv_cfg_t    cfg;
  dconv_pkg::window_beat_t window;
  dconv_pkg::acc_beat_t    acc;
  logic [15:0]             out_count;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  dconv_reg_decode u_reg_decode (
    .clk      (clk),
    .reset    (reset),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .out_count(out_count),
    .cfg      (cfg)
  );

  ////////////////////////////////////////
  // Execute
  ////////////////////////////////////////

  // Window in cycle 1 after the pixel edge
  dconv_window_gather u_window_gather (
    .clk   (clk),
    .reset (reset),
    .pxl_in(pxl_in),
    .enable(cfg.enable),
    .window(window)
  );

  // Accumulator in cycle 3
  dconv_mac_array u_mac_array (
    .clk   (clk),
    .reset (reset),
    .window(window),
    .cfg   (cfg),
    .acc   (acc)
  );

  ////////////////////////////////////////
  // Result
  ////////////////////////////////////////

  // Result pixel in cycle 4
  dconv_requant u_requant (
    .clk      (clk),
    .reset    (reset),
    .acc      (acc),
    .cfg      (cfg),
    .result   (result),
    .out_count(out_count)
  );

endmodule

`default_nettype wire

//--- verif/dconv_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "dconv_config.svh"

module dconv_tb;

  localparam int W          = `IMAGE_WIDTH;
  localparam int H          = `IMAGE_HEIGHT;
  localparam int R          = `RATE;
  localparam int FRAME_OUTS = (H - 2 * R) * (W - 2 * R);
  localparam int NUM_FRAMES = 10;
  localparam int APB_CYCLES = 200 * 3;
  localparam int MAX_CYCLES = NUM_FRAMES * W * H * 4 + APB_CYCLES + 500;
  localparam logic [31:0] SEED = 32'h6c8a_5011;

  logic                 clk;
  logic                 reset;
  dconv_pkg::apb_req_t  apb_req;
  dconv_pkg::apb_rsp_t  apb_rsp;
  dconv_pkg::pxl_beat_t pxl_in;
  dconv_pkg::pxl_beat_t result;

  // Reference model state
  int          w [9];
  int          bias;
  int          shift;
  bit          relu;
  bit          enable;
  int          pix [H][W];
  logic [15:0] exp_q [$];
  int          lat_q [$];
  logic [15:0] mon_data;
  int          mon_edge;
  int          cycles;
  int          errors;
  int          res_count;
  int          out_idx;
  int          test_num;
  int          test_start;
  int          count_start;
  int          tests_failed;

  dconv_top dut0 (
    .clk    (clk),
    .reset  (reset),
    .apb_req(apb_req),
    .apb_rsp(apb_rsp),
    .pxl_in (pxl_in),
    .result (result)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run went past %0d cycles", MAX_CYCLES);
      $display("Result: FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Result monitor
  ////////////////////////////////////////

  // Compare each result beat with the model queue
  always @(negedge clk) begin
    if (!reset && result.valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Unexpected result beat at cycle %0d with no output pending", cycles);
      end else begin
        mon_data = exp_q.pop_front();
        mon_edge = lat_q.pop_front();
        if (result.data !== mon_data) begin
          errors++;
          $display("Error: result.data got %h expected %h", result.data, mon_data);
        end
        if (result.sof !== (out_idx == 0)) begin
          errors++;
          $display("Error: result.sof got %h expected %h", result.sof, out_idx == 0);
        end
        // Next rising edge is the one that samples this beat
        if (cycles + 1 != mon_edge) begin
          errors++;
          $display("Error: result.valid edge got %h expected %h", cycles + 1, mon_edge);
        end
      end
      out_idx = (out_idx == FRAME_OUTS - 1) ? 0 : out_idx + 1;
      res_count++;
    end
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic int rand_between(int lo, int hi);
    return lo + int'($urandom_range(hi - lo));
  endfunction

  function automatic logic [31:0] sext16(logic [31:0] v);
    return {{16{v[15]}}, v[15:0]};
  endfunction

  // Output (i,j) from the convolution rule
  function automatic logic [15:0] model_pixel(int i, int j);
    longint acc;
    longint q;
    acc = longint'(bias) <<< shift;
    for (int ky = 0; ky < 3; ky++) begin
      for (int kx = 0; kx < 3; kx++) begin
        acc += longint'(w[3 * ky + kx]) * longint'(pix[i + R * ky][j + R * kx]);
      end
    end
    q = acc >>> shift;
    if (relu && q < 0) q = 0;
    if (q > 32767) q = 32767;
    else if (q < -32768) q = -32768;
    return q[15:0];
  endfunction

  task automatic apb_xfer(input bit write, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clk);
    apb_req.penable = 1'b1;
    #1;
    if (apb_rsp.pready !== 1'b1) begin
      errors++;
      $display("Error: apb_rsp.pready got %h expected 1", apb_rsp.pready);
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(negedge clk);
    apb_req = '0;
  endtask

  task automatic apb_check_write(input logic [7:0] addr, input logic [31:0] data,
                                 input bit exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b1, addr, data, rdata, err);
    if (err !== exp_err) begin
      errors++;
      $display("Error: apb_rsp.pslverr on write 0x%02h got %h expected %h", addr, err, exp_err);
    end
  endtask

  task automatic apb_check_read(input logic [7:0] addr, input logic [31:0] exp,
                                input bit exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b0, addr, 32'd0, rdata, err);
    if (err !== exp_err) begin
      errors++;
      $display("Error: apb_rsp.pslverr on read 0x%02h got %h expected %h", addr, err, exp_err);
    end
    if (rdata !== exp) begin
      errors++;
      $display("Error: apb_rsp.prdata at 0x%02h got %h expected %h", addr, rdata, exp);
    end
  endtask

  task automatic apply_config();
    for (int k = 0; k < 9; k++) begin
      apb_check_write(8'(4 * k), 32'(w[k]), 1'b0);
    end
    apb_check_write(8'h24, 32'(bias), 1'b0);
    apb_check_write(8'h28, 32'(shift), 1'b0);
    apb_check_write(8'h2c, {30'd0, relu, enable}, 1'b0);
  endtask

  task automatic randomize_small();
    for (int k = 0; k < 9; k++) begin
      w[k] = rand_between(-8, 8);
    end
    bias   = rand_between(-100, 100);
    shift  = rand_between(0, 4);
    relu   = 1'($urandom_range(1));
    enable = 1'b1;
  endtask

  // One frame with random pixels in [lo, hi] and random idle gaps
  task automatic send_frame(input int lo, input int hi, input int gap_max);
    int gaps;
    for (int r = 0; r < H; r++) begin
      for (int c = 0; c < W; c++) begin
        pix[r][c] = rand_between(lo, hi);
      end
    end
    if (enable) begin
      for (int i = 0; i < H - 2 * R; i++) begin
        for (int j = 0; j < W - 2 * R; j++) begin
          exp_q.push_back(model_pixel(i, j));
        end
      end
    end
    for (int r = 0; r < H; r++) begin
      for (int c = 0; c < W; c++) begin
        @(negedge clk);
        pxl_in.valid = 1'b1;
        pxl_in.sof   = (r == 0 && c == 0);
        pxl_in.data  = 16'(pix[r][c]);
        // Pixel completes a window, sampled at edge cycles+1
        if (enable && r >= 2 * R && c >= 2 * R) lat_q.push_back(cycles + 1 + 4);
        gaps = int'($urandom_range(gap_max));
        repeat (gaps) begin
          @(negedge clk);
          pxl_in = '0;
        end
      end
    end
    @(negedge clk);
    pxl_in = '0;
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) @(negedge clk);
    repeat (6) @(negedge clk);
  endtask

  task automatic start_test();
    test_num++;
    test_start  = errors;
    count_start = res_count;
  endtask

  task automatic report_test(input string name);
    if (errors == test_start) begin
      $display("Test %0d %s: ok", test_num, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: failed with %0d errors", test_num, name, errors - test_start);
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    logic [31:0] val;
    logic [31:0] reg_exp [13];
    clk = 1'b0;
    reset = 1'b1;
    apb_req = '0;
    pxl_in = '0;
    cycles = 0;
    errors = 0;
    res_count = 0;
    out_idx = 0;
    test_num = 0;
    tests_failed = 0;
    void'($urandom(SEED));
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Register access and bad accesses
    start_test();
    for (int k = 0; k < 12; k++) begin
      val = $urandom;
      apb_check_write(8'(4 * k), val, 1'b0);
      if (k < 10) reg_exp[k] = sext16(val);
      else if (k == 10) reg_exp[k] = {27'd0, val[4:0]};
      else reg_exp[k] = {30'd0, val[1:0]};
    end
    reg_exp[12] = 32'd0;
    for (int k = 0; k < 13; k++) apb_check_read(8'(4 * k), reg_exp[k], 1'b0);
    apb_check_write(8'h34, $urandom, 1'b1);
    apb_check_write(8'h30, $urandom, 1'b1);
    apb_check_write(8'h44, $urandom, 1'b1);
    apb_check_read(8'h34, 32'd0, 1'b1);
    apb_check_read(8'h40, 32'd0, 1'b1);
    for (int k = 0; k < 13; k++) apb_check_read(8'(4 * k), reg_exp[k], 1'b0);
    report_test("register access");

    // Identity kernel
    start_test();
    for (int k = 0; k < 9; k++) w[k] = 0;
    w[4] = 1;
    bias = 0;
    shift = 0;
    relu = 1'b0;
    enable = 1'b1;
    apply_config();
    send_frame(-1000, 1000, 3);
    wait_drained();
    if (res_count - count_start != FRAME_OUTS) begin
      errors++;
      $display("Error: result beat count got %h expected %h", res_count - count_start, FRAME_OUTS);
    end
    report_test("identity kernel");

    // Two configurations, two back-to-back frames each
    start_test();
    repeat (2) begin
      randomize_small();
      apply_config();
      send_frame(-500, 500, 3);
      send_frame(-500, 500, 3);
      wait_drained();
    end
    report_test("random frames");

    // Clamp high, clamp low, then ReLU
    start_test();
    for (int k = 0; k < 9; k++) w[k] = 20000;
    bias = 0;
    shift = 0;
    relu = 1'b0;
    apply_config();
    send_frame(10000, 30000, 3);
    wait_drained();
    for (int k = 0; k < 9; k++) w[k] = -20000;
    apply_config();
    send_frame(10000, 30000, 3);
    wait_drained();
    relu = 1'b1;
    apply_config();
    send_frame(10000, 30000, 3);
    wait_drained();
    report_test("saturation and relu");

    // Disabled frame, then the output counter
    start_test();
    enable = 1'b0;
    apply_config();
    send_frame(-500, 500, 3);
    repeat (10) @(negedge clk);
    if (res_count != count_start) begin
      $display("Pixels sent with enable low produced %0d result beats", res_count - count_start);
      errors++;
    end
    apb_check_read(8'h30, {16'd0, res_count[15:0]}, 1'b0);
    report_test("enable and counter");

    // Latency is checked on every result beat by the monitor
    start_test();
    randomize_small();
    apply_config();
    send_frame(-500, 500, 3);
    wait_drained();
    report_test("latency");

    $display("Tests run %0d, failed %0d, errors %0d", test_num, tests_failed, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+rtl
rtl/dconv_pkg.sv
rtl/dconv_reg_decode.sv
rtl/dconv_window_gather.sv
rtl/dconv_mac_array.sv
rtl/dconv_requant.sv
rtl/dconv_top.sv
verif/dconv_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the dconv testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f sources.f --top-module dconv_tb \
  -Mdir obj_dir -o dconv_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/dconv_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "Result: PASSED" "$LOG"; then
  echo "No pass line found in $LOG"
  exit 1
fi
exit 0
